//--- common/usb_pm_pkg.sv
// Power-management types; limits count 48 MHz cycles and the event record is 7 bits.
`default_nettype none

package usb_pm_pkg;

    // Power states of the controller.
    typedef enum logic [1:0] {
        ACTIVE  = 2'd0,
        IDLE    = 2'd1,
        SUSPEND = 2'd2,
        RESUME  = 2'd3
    } pm_state_t;

    // Reason for a state change.
    typedef enum logic [2:0] {
        IDLE_TIMEOUT    = 3'd0,
        SW_SUSPEND      = 3'd1,
        BUS_WAKE        = 3'd2,
        SW_RESUME       = 3'd3,
        SUSPEND_TIMEOUT = 3'd4,
        RESUME_DONE     = 3'd5
    } pm_cause_t;

    // Event record, laid out as the EVENT register: cause[6:4], to[3:2], from[1:0].
    typedef struct packed {
        pm_cause_t cause;
        pm_state_t to_state;
        pm_state_t from_state;
    } pm_event_t;

    // Programmable timing limits.
    typedef struct packed {
        logic [15:0] idle_limit;
        logic [15:0] suspend_limit;
        logic [15:0] resume_time;
    } pm_limits_t;

    localparam pm_limits_t pm_limits_reset = '{
        idle_limit:    16'd3000,
        suspend_limit: 16'd20000,
        resume_time:   16'd1000
    };

endpackage

`default_nettype wire

//--- common/apb_pkg.sv
// APB request and response bundles with an 8-bit byte address and 32-bit data.
`default_nettype none

package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // Register map of the power manager.
    typedef enum logic [7:0] {
        CTRL          = 8'h00,
        STATUS        = 8'h04,
        IDLE_LIMIT    = 8'h08,
        SUSPEND_LIMIT = 8'h0C,
        RESUME_TIME   = 8'h10,
        EVENT         = 8'h14
    } pm_reg_addr_t;

endpackage

`default_nettype wire

//--- rtl/line_activity_detector.sv
// Activity is anything but J on D+/D-, plus one cycle after each change; latency is 3 cycles.
`timescale 1ns/100ps
`default_nettype none

module line_activity_detector (
    input  logic clk_48mhz,
    input  logic reset_n,
    input  logic dp,
    input  logic dm,
    output logic bus_activity
);

    // Full-speed idle J state is D+ high, D- low.
    localparam logic [1:0] LINE_J = 2'b10;

    logic [1:0] line_meta;
    logic [1:0] line_sync;
    logic [1:0] line_prev;
    logic       not_j;
    logic       changed;

    // Two-flop synchronizer, reset to J so that no activity is seen out of reset.
    always_ff @(posedge clk_48mhz or negedge reset_n) begin
        if (!reset_n) begin
            line_meta <= LINE_J;
            line_sync <= LINE_J;
            line_prev <= LINE_J;
        end else begin
            line_meta <= {dp, dm};
            line_sync <= line_meta;
            line_prev <= line_sync;
        end
    end

    assign not_j   = line_sync != LINE_J;
    assign changed = line_sync != line_prev;

    always_ff @(posedge clk_48mhz or negedge reset_n) begin
        if (!reset_n) begin
            bus_activity <= 1'b0;
        end else begin
            bus_activity <= not_j || changed;
        end
    end

    // The controller must never see an unknown activity flag.
    assert property (@(posedge clk_48mhz) disable iff (!reset_n)
        !$isunknown(bus_activity));

endmodule

`default_nettype wire

//--- power_ctrl/usb_low_power_ctrl.sv
// One 16-bit counter serves idle, suspend and resume timing; clk_en and pll_en are plain flags.
`timescale 1ns/100ps
`default_nettype none

module usb_low_power_ctrl (
    input  logic                   clk_48mhz,
    input  logic                   reset_n,
    input  logic                   bus_activity,
    input  logic                   suspend_req,
    input  logic                   resume_req,
    input  usb_pm_pkg::pm_limits_t limits,
    output usb_pm_pkg::pm_state_t  state,
    output logic                   suspend_state,
    output logic                   clk_en,
    output logic                   pll_en,
    output logic                   event_valid,
    output usb_pm_pkg::pm_event_t  event_rec
);

    import usb_pm_pkg::*;

    pm_state_t   next_state;
    pm_cause_t   next_cause;
    logic [15:0] counter;
    logic [15:0] counter_inc;
    logic [15:0] counter_next;
    logic        transition;

    assign counter_inc = counter + 16'd1;

    always_comb begin
        next_state   = state;
        next_cause   = IDLE_TIMEOUT;
        counter_next = counter;
        case (state)
            ACTIVE: begin
                if (bus_activity) begin
                    counter_next = '0;
                end else if (suspend_req) begin
                    next_state = IDLE;
                    next_cause = SW_SUSPEND;
                end else if (counter >= limits.idle_limit) begin
                    next_state = IDLE;
                    next_cause = IDLE_TIMEOUT;
                end else begin
                    counter_next = counter_inc;
                end
            end
            IDLE: begin
                if (bus_activity) begin
                    next_state   = ACTIVE;
                    next_cause   = BUS_WAKE;
                    counter_next = '0;
                end else if (counter >= limits.suspend_limit) begin
                    next_state = SUSPEND;
                    next_cause = SUSPEND_TIMEOUT;
                end else begin
                    counter_next = counter_inc;
                end
            end
            SUSPEND: begin
                // Bus wake takes priority when both arrive together.
                if (bus_activity) begin
                    next_state   = RESUME;
                    next_cause   = BUS_WAKE;
                    counter_next = '0;
                end else if (resume_req) begin
                    next_state   = RESUME;
                    next_cause   = SW_RESUME;
                    counter_next = '0;
                end
            end
            RESUME: begin
                if (counter >= limits.resume_time) begin
                    next_state   = ACTIVE;
                    next_cause   = RESUME_DONE;
                    counter_next = '0;
                end else begin
                    counter_next = counter_inc;
                end
            end
        endcase
    end

    assign transition = next_state != state;

    // Output flags change only on the edge that enters a state.
    always_ff @(posedge clk_48mhz or negedge reset_n) begin
        if (!reset_n) begin
            state         <= ACTIVE;
            counter       <= '0;
            suspend_state <= 1'b0;
            clk_en        <= 1'b1;
            pll_en        <= 1'b1;
            event_valid   <= 1'b0;
        end else begin
            state       <= next_state;
            counter     <= counter_next;
            event_valid <= transition;
            if (transition) begin
                case (next_state)
                    SUSPEND: begin
                        suspend_state <= 1'b1;
                        clk_en        <= 1'b0;
                        pll_en        <= 1'b0;
                    end
                    RESUME: begin
                        pll_en <= 1'b1;
                    end
                    ACTIVE: begin
                        clk_en        <= 1'b1;
                        suspend_state <= 1'b0;
                    end
                    default: begin
                        // Entering IDLE leaves the flags as they were in ACTIVE.
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_48mhz) begin
        if (transition) begin
            event_rec <= '{cause: next_cause, to_state: next_state, from_state: state};
        end
    end

    // The core clock never runs without the PLL.
    assert property (@(posedge clk_48mhz) disable iff (!reset_n)
        clk_en |-> pll_en);

    assert property (@(posedge clk_48mhz) disable iff (!reset_n)
        suspend_state == ((state == SUSPEND) || (state == RESUME)));

endmodule

`default_nettype wire

//--- rtl/pm_event_fifo.sv
// EVENT_DEPTH must be a power of two, at least 2; a push into a full FIFO is lost.
`timescale 1ns/100ps
`default_nettype none

module pm_event_fifo #(
    parameter int EVENT_DEPTH = 8
) (
    input  logic                          clk_48mhz,
    input  logic                          reset_n,
    input  logic                          push,
    input  usb_pm_pkg::pm_event_t         push_rec,
    input  logic                          pop,
    input  logic                          clear_overflow,
    output usb_pm_pkg::pm_event_t         head_rec,
    output logic [$clog2(EVENT_DEPTH):0]  count,
    output logic                          overflow
);

    import usb_pm_pkg::*;

    localparam int PTR_W = $clog2(EVENT_DEPTH);

    pm_event_t        mem [EVENT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full     = count == (PTR_W + 1)'(EVENT_DEPTH);
    assign do_pop   = pop && (count != '0);
    // A pop on the same edge frees the slot for the push.
    assign do_push  = push && (!full || do_pop);
    assign head_rec = mem[rd_ptr];

    always_ff @(posedge clk_48mhz) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    always_ff @(posedge clk_48mhz or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
            if (clear_overflow) begin
                overflow <= 1'b0;
            end
            // A new drop wins over a clear on the same edge.
            if (push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk_48mhz) disable iff (!reset_n)
        pop |-> count != '0);

endmodule

`default_nettype wire

//--- rtl/pm_apb_regs.sv
// No wait states; STATUS holds a 4-bit FIFO count, so EVENT_DEPTH is at most 8.
`timescale 1ns/100ps
`default_nettype none

module pm_apb_regs #(
    parameter int EVENT_DEPTH = 8
) (
    input  logic                          clk_48mhz,
    input  logic                          reset_n,
    input  apb_pkg::apb_req_t             apb_req,
    output apb_pkg::apb_rsp_t             apb_rsp,
    input  usb_pm_pkg::pm_state_t         state,
    input  logic [$clog2(EVENT_DEPTH):0]  fifo_count,
    input  logic                          overflow,
    input  usb_pm_pkg::pm_event_t         head_rec,
    output usb_pm_pkg::pm_limits_t        limits,
    output logic                          suspend_req,
    output logic                          resume_req,
    output logic                          pop,
    output logic                          clear_overflow
);

    import usb_pm_pkg::*;
    import apb_pkg::*;

    pm_reg_addr_t reg_addr;
    logic         access;
    logic         wr;
    logic         rd;
    logic         mapped;
    logic         fifo_empty;
    logic         ctrl_wr;
    logic [3:0]   count_field;
    logic [31:0]  rdata;

    assign reg_addr    = pm_reg_addr_t'(apb_req.paddr);
    assign access      = apb_req.psel && apb_req.penable;
    assign wr          = access && apb_req.pwrite;
    assign rd          = access && !apb_req.pwrite;
    assign fifo_empty  = fifo_count == '0;
    assign ctrl_wr     = wr && (reg_addr == CTRL);
    assign count_field = 4'(fifo_count);

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (reg_addr)
            CTRL:          rdata = '0;
            STATUS:        rdata = {23'd0, overflow, count_field, 2'd0, state};
            IDLE_LIMIT:    rdata = {16'd0, limits.idle_limit};
            SUSPEND_LIMIT: rdata = {16'd0, limits.suspend_limit};
            RESUME_TIME:   rdata = {16'd0, limits.resume_time};
            EVENT:         rdata = fifo_empty ? '0 : {25'd0, head_rec};
            default:       mapped = 1'b0;
        endcase
    end

    assign apb_rsp.pready  = access;
    assign apb_rsp.prdata  = rd ? rdata : '0;
    assign apb_rsp.pslverr = access && (!mapped ||
                             (apb_req.pwrite && (reg_addr == STATUS || reg_addr == EVENT)) ||
                             (!apb_req.pwrite && reg_addr == EVENT && fifo_empty));

    // Pop and clear act on the access edge itself.
    assign pop            = rd && (reg_addr == EVENT) && !fifo_empty;
    assign clear_overflow = ctrl_wr && apb_req.pwdata[2];

    always_ff @(posedge clk_48mhz or negedge reset_n) begin
        if (!reset_n) begin
            limits      <= pm_limits_reset;
            suspend_req <= 1'b0;
            resume_req  <= 1'b0;
        end else begin
            suspend_req <= ctrl_wr && apb_req.pwdata[0];
            resume_req  <= ctrl_wr && apb_req.pwdata[1];
            if (wr && reg_addr == IDLE_LIMIT) begin
                limits.idle_limit <= apb_req.pwdata[15:0];
            end
            if (wr && reg_addr == SUSPEND_LIMIT) begin
                limits.suspend_limit <= apb_req.pwdata[15:0];
            end
            if (wr && reg_addr == RESUME_TIME) begin
                limits.resume_time <= apb_req.pwdata[15:0];
            end
        end
    end

    assert property (@(posedge clk_48mhz) disable iff (!reset_n)
        apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

//--- rtl/usb_pm_top.sv
// USB suspend/resume manager without SE0 reset or remote wakeup; EVENT_DEPTH from 2 to 8.
`timescale 1ns/100ps
`default_nettype none

module usb_pm_top #(
    parameter int EVENT_DEPTH = 8
) (
    input  logic              clk_48mhz,
    input  logic              reset_n,
    input  logic              dp,
    input  logic              dm,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    output logic              suspend_state,
    output logic              clk_en,
    output logic              pll_en
);

    import usb_pm_pkg::*;

    localparam int CNT_W = $clog2(EVENT_DEPTH) + 1;

    logic             bus_activity;
    pm_limits_t       limits;
    logic             suspend_req;
    logic             resume_req;
    pm_state_t        state;
    logic             event_valid;
    pm_event_t        event_rec;
    pm_event_t        head_rec;
    logic [CNT_W-1:0] fifo_count;
    logic             overflow;
    logic             pop;
    logic             clear_overflow;

    line_activity_detector line_activity_detector_inst (
        .clk_48mhz    (clk_48mhz),
        .reset_n      (reset_n),
        .dp           (dp),
        .dm           (dm),
        .bus_activity (bus_activity)
    );

    usb_low_power_ctrl usb_low_power_ctrl_inst (
        .clk_48mhz     (clk_48mhz),
        .reset_n       (reset_n),
        .bus_activity  (bus_activity),
        .suspend_req   (suspend_req),
        .resume_req    (resume_req),
        .limits        (limits),
        .state         (state),
        .suspend_state (suspend_state),
        .clk_en        (clk_en),
        .pll_en        (pll_en),
        .event_valid   (event_valid),
        .event_rec     (event_rec)
    );

    pm_event_fifo #(
        .EVENT_DEPTH (EVENT_DEPTH)
    ) pm_event_fifo_inst (
        .clk_48mhz      (clk_48mhz),
        .reset_n        (reset_n),
        .push           (event_valid),
        .push_rec       (event_rec),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .head_rec       (head_rec),
        .count          (fifo_count),
        .overflow       (overflow)
    );

    pm_apb_regs #(
        .EVENT_DEPTH (EVENT_DEPTH)
    ) pm_apb_regs_inst (
        .clk_48mhz      (clk_48mhz),
        .reset_n        (reset_n),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .state          (state),
        .fifo_count     (fifo_count),
        .overflow       (overflow),
        .head_rec       (head_rec),
        .limits         (limits),
        .suspend_req    (suspend_req),
        .resume_req     (resume_req),
        .pop            (pop),
        .clear_overflow (clear_overflow)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// Free-running 48 MHz testbench clock (20 ns period here); reset_n is released after 10 edges.
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_48mhz,
    output logic reset_n
);

    initial begin
        clk_48mhz = 1'b0;
        forever #10 clk_48mhz = ~clk_48mhz;
    end

    initial begin
        reset_n = 1'b0;
        repeat (10) @(posedge clk_48mhz);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/usb_pm_tb.sv
// Directed tests with a 4-deep event FIFO; limits are shrunk early so every wait stays short.
`timescale 1ns/100ps
`default_nettype none

module usb_pm_tb;

    import usb_pm_pkg::*;
    import apb_pkg::*;

    localparam int          IDLE_SMALL    = 20;
    localparam int          SUSPEND_SMALL = 40;
    localparam int          RESUME_SMALL  = 10;
    localparam int          WAIT_LIMIT    = 3000;
    localparam int          POLL_LIMIT    = 200;
    localparam logic [31:0] CTRL_SUSPEND  = 32'h1;
    localparam logic [31:0] CTRL_RESUME   = 32'h2;
    localparam logic [31:0] CTRL_CLR_OVF  = 32'h4;

    logic     clk_48mhz;
    logic     reset_n;
    logic     dp;
    logic     dm;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     suspend_state;
    logic     clk_en;
    logic     pll_en;

    int       errors;
    int       timeouts;
    string    current_test;

    tb_clock_gen tb_clock_gen_inst (
        .clk_48mhz (clk_48mhz),
        .reset_n   (reset_n)
    );

    usb_pm_top #(
        .EVENT_DEPTH (4)
    ) usb_pm_top_inst (
        .clk_48mhz     (clk_48mhz),
        .reset_n       (reset_n),
        .dp            (dp),
        .dm            (dm),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .suspend_state (suspend_state),
        .clk_en        (clk_en),
        .pll_en        (pll_en)
    );

    // EVENT word with cause in 6:4, to-state in 3:2 and from-state in 1:0.
    function automatic logic [31:0] event_word(input pm_state_t from_state,
                                               input pm_state_t to_state,
                                               input pm_cause_t cause);
        return {25'd0, cause, to_state, from_state};
    endfunction

    // STATUS word with overflow in bit 8, count in 7:4 and state in 1:0.
    function automatic logic [31:0] status_word(input pm_state_t st, input int count,
                                                input logic ovf);
        return {23'd0, ovf, 4'(count), 2'd0, st};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("ERR %s %s: expected 0x%0h, actual 0x%0h",
                     current_test, what, expected, actual);
        end
    endtask

    // One setup and one access phase; the response is sampled mid access phase.
    task automatic bus_cycle(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, input logic expect_err,
                             output logic [31:0] rdata);
        @(posedge clk_48mhz);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk_48mhz);
        apb_req.penable <= 1'b1;
        @(negedge clk_48mhz);
        check_value($sformatf("pready @0x%02h", addr), 32'd1, apb_rsp.pready);
        check_value($sformatf("pslverr @0x%02h", addr), expect_err, apb_rsp.pslverr);
        rdata = apb_rsp.prdata;
        @(posedge clk_48mhz);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic expect_err);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, expect_err, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic expect_err,
                            output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'd0, expect_err, data);
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected,
                              input string what);
        logic [31:0] data;
        apb_read(addr, 1'b0, data);
        check_value(what, expected, data);
    endtask

    task automatic expect_event(input pm_state_t from_state, input pm_state_t to_state,
                                input pm_cause_t cause);
        read_check(EVENT, event_word(from_state, to_state, cause), $sformatf("EVENT %s",
                   cause.name()));
    endtask

    // K drives D+ low and D- high while J is the idle state.
    task automatic drive_line(input logic k_state, input int cycles);
        @(posedge clk_48mhz);
        dp <= ~k_state;
        dm <= k_state;
        repeat (cycles) @(posedge clk_48mhz);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (reset_n !== 1'b1 && n < 100) begin
            @(negedge clk_48mhz);
            n++;
        end
        assert (reset_n === 1'b1) else begin
            timeouts++;
            $display("Timeout: reset_n was never released");
        end
        @(negedge clk_48mhz);
    endtask

    // The pll_en and clk_en pair tells SUSPEND (00), RESUME (10) and ACTIVE or IDLE (11).
    task automatic wait_power_flags(input logic want_pll, input logic want_clk,
                                    input string what, output int cycles);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk_48mhz);
            n++;
            done = (pll_en === want_pll) && (clk_en === want_clk);
        end
        cycles = n;
        assert (done) else begin
            timeouts++;
            $display("Timeout in %s: pll_en and clk_en did not settle for %s",
                     current_test, what);
        end
    endtask

    task automatic wait_state(input pm_state_t want);
        logic [31:0] data;
        int          n;
        logic        done;
        n = 0;
        done = 1'b0;
        while (!done && n < POLL_LIMIT) begin
            apb_read(STATUS, 1'b0, data);
            n++;
            done = data[1:0] == want;
        end
        assert (done) else begin
            timeouts++;
            $display("Timeout in %s: STATUS never showed state %s", current_test, want.name());
        end
    endtask

    task automatic reset_and_registers();
        current_test = "reset_and_registers";
        check_value("clk_en", 32'd1, clk_en);
        check_value("pll_en", 32'd1, pll_en);
        check_value("suspend_state", 32'd0, suspend_state);
        read_check(STATUS, status_word(ACTIVE, 0, 1'b0), "STATUS");
        read_check(IDLE_LIMIT, 32'd3000, "IDLE_LIMIT");
        read_check(SUSPEND_LIMIT, 32'd20000, "SUSPEND_LIMIT");
        read_check(RESUME_TIME, 32'd1000, "RESUME_TIME");
        read_check(CTRL, 32'd0, "CTRL");
        apb_write(IDLE_LIMIT, IDLE_SMALL, 1'b0);
        apb_write(SUSPEND_LIMIT, SUSPEND_SMALL, 1'b0);
        apb_write(RESUME_TIME, RESUME_SMALL, 1'b0);
        read_check(IDLE_LIMIT, IDLE_SMALL, "IDLE_LIMIT");
        read_check(SUSPEND_LIMIT, SUSPEND_SMALL, "SUSPEND_LIMIT");
        read_check(RESUME_TIME, RESUME_SMALL, "RESUME_TIME");
    endtask

    task automatic idle_timeout_to_suspend();
        logic [31:0] data;
        int          cycles;
        current_test = "idle_timeout_to_suspend";
        wait_power_flags(1'b0, 1'b0, "SUSPEND", cycles);
        check_value("suspend_state", 32'd1, suspend_state);
        read_check(STATUS, status_word(SUSPEND, 2, 1'b0), "STATUS");
        expect_event(ACTIVE, IDLE, IDLE_TIMEOUT);
        expect_event(IDLE, SUSPEND, SUSPEND_TIMEOUT);
        apb_read(EVENT, 1'b1, data);
        check_value("empty EVENT prdata", 32'd0, data);
    endtask

    task automatic software_resume();
        int cycles;
        current_test = "software_resume";
        apb_write(CTRL, CTRL_RESUME, 1'b0);
        wait_power_flags(1'b1, 1'b0, "RESUME", cycles);
        check_value("suspend_state in RESUME", 32'd1, suspend_state);
        wait_power_flags(1'b1, 1'b1, "ACTIVE", cycles);
        // The counter restarts at zero and leaves once it reaches resume_time.
        check_value("cycles from pll_en to clk_en", RESUME_SMALL + 1, cycles);
        check_value("suspend_state in ACTIVE", 32'd0, suspend_state);
        expect_event(SUSPEND, RESUME, SW_RESUME);
        expect_event(RESUME, ACTIVE, RESUME_DONE);
        wait_power_flags(1'b0, 1'b0, "SUSPEND", cycles);
        expect_event(ACTIVE, IDLE, IDLE_TIMEOUT);
        expect_event(IDLE, SUSPEND, SUSPEND_TIMEOUT);
        read_check(STATUS, status_word(SUSPEND, 0, 1'b0), "STATUS");
    endtask

    task automatic bus_wake();
        int cycles;
        current_test = "bus_wake";
        drive_line(1'b1, 4);
        drive_line(1'b0, 1);
        wait_power_flags(1'b1, 1'b1, "ACTIVE", cycles);
        expect_event(SUSPEND, RESUME, BUS_WAKE);
        expect_event(RESUME, ACTIVE, RESUME_DONE);
        wait_power_flags(1'b0, 1'b0, "SUSPEND", cycles);
        expect_event(ACTIVE, IDLE, IDLE_TIMEOUT);
        expect_event(IDLE, SUSPEND, SUSPEND_TIMEOUT);

        // Long limits hold ACTIVE and IDLE while software and the bus act.
        apb_write(IDLE_LIMIT, 32'd1000, 1'b0);
        apb_write(SUSPEND_LIMIT, 32'd2000, 1'b0);
        apb_write(CTRL, CTRL_RESUME, 1'b0);
        wait_power_flags(1'b1, 1'b1, "ACTIVE", cycles);
        apb_write(CTRL, CTRL_SUSPEND, 1'b0);
        wait_state(IDLE);
        drive_line(1'b1, 4);
        drive_line(1'b0, 1);
        wait_state(ACTIVE);
        expect_event(SUSPEND, RESUME, SW_RESUME);
        expect_event(RESUME, ACTIVE, RESUME_DONE);
        expect_event(ACTIVE, IDLE, SW_SUSPEND);
        expect_event(IDLE, ACTIVE, BUS_WAKE);
        apb_write(IDLE_LIMIT, IDLE_SMALL, 1'b0);
        apb_write(SUSPEND_LIMIT, SUSPEND_SMALL, 1'b0);
        wait_power_flags(1'b0, 1'b0, "SUSPEND", cycles);
        expect_event(ACTIVE, IDLE, IDLE_TIMEOUT);
        expect_event(IDLE, SUSPEND, SUSPEND_TIMEOUT);
    endtask

    task automatic event_overflow();
        int cycles;
        current_test = "event_overflow";
        // Two resume rounds push eight records into four slots.
        repeat (2) begin
            apb_write(CTRL, CTRL_RESUME, 1'b0);
            wait_power_flags(1'b1, 1'b0, "RESUME", cycles);
            wait_power_flags(1'b0, 1'b0, "SUSPEND", cycles);
        end
        read_check(STATUS, status_word(SUSPEND, 4, 1'b1), "STATUS full");
        // Illegal writes must neither clear the flag nor pop a record.
        apb_write(STATUS, 32'h0000_8103, 1'b1);
        apb_write(EVENT, 32'h0000_007f, 1'b1);
        read_check(STATUS, status_word(SUSPEND, 4, 1'b1), "STATUS after illegal writes");
        expect_event(SUSPEND, RESUME, SW_RESUME);
        expect_event(RESUME, ACTIVE, RESUME_DONE);
        expect_event(ACTIVE, IDLE, IDLE_TIMEOUT);
        expect_event(IDLE, SUSPEND, SUSPEND_TIMEOUT);
        read_check(STATUS, status_word(SUSPEND, 0, 1'b1), "STATUS drained");
        apb_write(CTRL, CTRL_CLR_OVF, 1'b0);
        read_check(STATUS, status_word(SUSPEND, 0, 1'b0), "STATUS cleared");
    endtask

    task automatic apb_errors();
        logic [31:0] data;
        current_test = "apb_errors";
        apb_write(8'h18, 32'h0000_ffff, 1'b1);
        apb_write(8'h09, 32'h0000_ffff, 1'b1);
        apb_read(8'h40, 1'b1, data);
        apb_write(STATUS, 32'h0000_8103, 1'b1);
        apb_write(EVENT, 32'h0000_007f, 1'b1);
        read_check(STATUS, status_word(SUSPEND, 0, 1'b0), "STATUS");
        read_check(IDLE_LIMIT, IDLE_SMALL, "IDLE_LIMIT");
        read_check(SUSPEND_LIMIT, SUSPEND_SMALL, "SUSPEND_LIMIT");
        read_check(RESUME_TIME, RESUME_SMALL, "RESUME_TIME");
        apb_read(EVENT, 1'b1, data);
        check_value("suspend_state", 32'd1, suspend_state);
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        current_test = "startup";
        apb_req = '0;
        dp = 1'b1;
        dm = 1'b0;
        wait_reset();
        reset_and_registers();
        idle_timeout_to_suspend();
        software_resume();
        bus_wake();
        event_overflow();
        apb_errors();
        $display("Failed checks: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/usb_pm_pkg.sv
common/apb_pkg.sv
rtl/line_activity_detector.sv
power_ctrl/usb_low_power_ctrl.sv
rtl/pm_event_fifo.sv
rtl/pm_apb_regs.sv
rtl/usb_pm_top.sv
verif/tb_clock_gen.sv
verif/usb_pm_tb.sv

//--- Bender.yml
package:
  name: usb_pm

sources:
  - common/usb_pm_pkg.sv
  - common/apb_pkg.sv
  - rtl/line_activity_detector.sv
  - power_ctrl/usb_low_power_ctrl.sv
  - rtl/pm_event_fifo.sv
  - rtl/pm_apb_regs.sv
  - rtl/usb_pm_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/usb_pm_tb.sv
